// ==== common/pbus_params.svh ====
`ifndef PBUS_PARAMS_SVH
`define PBUS_PARAMS_SVH

// Slot windows within one 32 clock line period
`define PBUS_SLOTS     32
`define PBUS_FIXT_END  5'd2
`define PBUS_FF_END    5'd13
`define PBUS_FP_END    5'd15
`define PBUS_SPRT_END  5'd18
`define PBUS_L0_END    5'd28
`define PBUS_L0_READ   5'd29

// nVCS phases, count modulo 16
`define PBUS_VCS_FALL  4'd9
`define PBUS_VCS_RISE  4'd14

// Wishbone register map
`define REG_FIXADDR    3'd0
`define REG_FIXPAL     3'd1
`define REG_SPRADDR    3'd2
`define REG_SPRATTR    3'd3
`define REG_L0ADDR     3'd4
`define REG_L0DATA     3'd5

`endif

// ==== common/pbus_pkg.sv ====
package pbus_pkg;

	// Fix layer request, one tile per line slot period
	typedef struct packed {
		logic [16:0] addr;	// Fix tile address
		logic [3:0]  pal;	// Fix palette
	} fixReq_t;

	// Sprite request
	typedef struct packed {
		logic [24:0] addr;	// Sprite tile address
		logic [7:0]  pal;	// Sprite palette
		logic [7:0]  xpos;	// Sprite X position
	} sprReq_t;

	// What the P-bus carries in a given slot window
	typedef enum logic [2:0] {
		FIXT = 3'd0,	// Fix tile address
		FF   = 3'd1,	// Constant FF0000
		FP   = 3'd2,	// Fix palette
		SPRT = 3'd3,	// Sprite tile address
		L0A  = 3'd4,	// L0 lookup address
		L0RD = 3'd5,	// L0 byte capture
		SP   = 3'd6	// Sprite X and palette
	} slotKind_t;

	// L0 ROM lookup address
	typedef logic [15:0] l0Addr_t;

endpackage

// ==== logic/reqLatch.sv ====
module reqLatch #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     CLK_24M,
	input  logic     nCLK_24M,
	input  logic     HSYNC,
	input  payload_t hostVal,
	output payload_t lineVal
);

	// Shadow copy, follows the host value only during HSYNC
	// so a whole line sees one consistent request
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
			lineVal <= '0;
		else if (HSYNC)
			lineVal <= hostVal;
	end

endmodule

// ==== logic/wbRegs.sv ====
`include "pbus_params.svh"

module wbRegs (
	input  logic              CLK_24M,
	input  logic              nCLK_24M,
	input  logic              wbCyc,
	input  logic              wbStb,
	input  logic              wbWe,
	input  logic [2:0]        wbAdr,
	input  logic [31:0]       wbDatW,
	output logic [31:0]       wbDatR,
	output logic              wbAck,
	output pbus_pkg::fixReq_t fixHost,
	output pbus_pkg::sprReq_t sprHost,
	output pbus_pkg::l0Addr_t l0AddrHost,
	input  logic [7:0]        l0Data
);

	import pbus_pkg::*;

	logic        accept;	// New access this clock
	logic [31:0] rdMux;

	// No ack pending means the strobe is a fresh request
	assign accept = wbCyc & wbStb & ~wbAck;

	always_comb
	begin
		rdMux = '0;
		case (wbAdr)
			`REG_FIXADDR: rdMux = {15'h0, fixHost.addr};
			`REG_FIXPAL:  rdMux = {28'h0, fixHost.pal};
			`REG_SPRADDR: rdMux = {7'h0, sprHost.addr};
			`REG_SPRATTR: rdMux = {16'h0, sprHost.pal, sprHost.xpos};
			`REG_L0ADDR:  rdMux = {16'h0, l0AddrHost};
			`REG_L0DATA:  rdMux = {24'h0, l0Data};
			default:      rdMux = '0;	// Unused addresses
		endcase
	end

	// Single cycle ack, read data registered alongside
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			wbAck  <= 1'b0;
			wbDatR <= '0;
		end
		else
		begin
			wbAck  <= accept;
			wbDatR <= accept ? rdMux : '0;
		end
	end

	// Host copies of the requests
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			fixHost    <= '0;
			sprHost    <= '0;
			l0AddrHost <= '0;
		end
		else if (accept && wbWe)
		begin
			case (wbAdr)
				`REG_FIXADDR: fixHost.addr <= wbDatW[16:0];
				`REG_FIXPAL:  fixHost.pal  <= wbDatW[3:0];
				`REG_SPRADDR: sprHost.addr <= wbDatW[24:0];
				`REG_SPRATTR:
				begin
					sprHost.pal  <= wbDatW[15:8];
					sprHost.xpos <= wbDatW[7:0];
				end
				`REG_L0ADDR:  l0AddrHost   <= wbDatW[15:0];
				default:      ;	// L0 data is read only
			endcase
		end
	end

endmodule

// ==== pbus/pbusSequencer.sv ====
`include "pbus_params.svh"

module pbusSequencer (
	input  logic                CLK_24M,
	input  logic                nCLK_24M,
	input  logic                HSYNC,
	output logic [4:0]          slotCount,
	output pbus_pkg::slotKind_t slotKind,
	output logic                PCK1,
	output logic                PCK2,
	output logic                LOAD,
	output logic                nVCS
);

	import pbus_pkg::*;

	// Slot counter, held at zero through HSYNC
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
			slotCount <= '0;
		else if (HSYNC)
			slotCount <= '0;
		else if (slotCount == 5'(`PBUS_SLOTS - 1))
			slotCount <= '0;	// Line wrap
		else
			slotCount <= slotCount + 5'd1;
	end

	// Window decode, boundaries are inclusive upper ends
	always_comb
	begin
		if (slotCount <= `PBUS_FIXT_END)
			slotKind = FIXT;
		else if (slotCount <= `PBUS_FF_END)
			slotKind = FF;
		else if (slotCount <= `PBUS_FP_END)
			slotKind = FP;
		else if (slotCount <= `PBUS_SPRT_END)
			slotKind = SPRT;
		else if (slotCount <= `PBUS_L0_END)
			slotKind = L0A;
		else if (slotCount == `PBUS_L0_READ)
			slotKind = L0RD;
		else
			slotKind = SP;	// 30 and 31
	end

	assign PCK2 = (slotCount[3:0] == 4'd0);	// 0, 16
	assign PCK1 = (slotCount[3:0] == 4'd8);	// 8, 24
	assign LOAD = slotCount[2] & slotCount[1];	// 6-7 every 8

	// nVCS low window in each half line
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
			nVCS <= 1'b1;
		else if (slotCount[3:0] == `PBUS_VCS_FALL)
			nVCS <= 1'b0;
		else if (slotCount[3:0] == `PBUS_VCS_RISE)
			nVCS <= 1'b1;
	end

endmodule

// ==== pbus/pbusDriver.sv ====
`include "pbus_params.svh"

module pbusDriver (
	input  logic                CLK_24M,
	input  logic                nCLK_24M,
	input  logic                HSYNC,
	input  logic [4:0]          slotCount,
	input  pbus_pkg::slotKind_t slotKind,
	input  pbus_pkg::fixReq_t   fixReq,
	input  pbus_pkg::sprReq_t   sprReq,
	input  pbus_pkg::l0Addr_t   l0AddrHost,
	input  logic [7:0]          pbusUpperIn,
	output logic [23:0]         pbusOut,
	output logic                pbusUpperOe,
	output logic [7:0]          l0Data
);

	import pbus_pkg::*;

	l0Addr_t l0Addr;	// Line copy of the L0 address

	// L0 address shadow, reloaded through HSYNC
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
			l0Addr <= '0;
		else if (HSYNC)
			l0Addr <= l0AddrHost;
	end

	// Bus word is one stage behind the counter
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			pbusOut     <= '0;
			pbusUpperOe <= 1'b0;
		end
		else
		begin
			pbusUpperOe <= 1'b1;
			case (slotKind)
				FIXT:
					pbusOut <= {8'h00, fixReq.addr[4], fixReq.addr[2:0], fixReq.addr[16:5]};
				FF:
					pbusOut <= 24'hFF0000;
				FP:
					pbusOut <= {4'h0, fixReq.pal, 16'h0000};
				SPRT:
					pbusOut <= {sprReq.addr[24:21], sprReq.addr[3:0], sprReq.addr[20:5]};
				L0A:
				begin
					pbusOut     <= {8'h00, l0Addr};
					pbusUpperOe <= 1'b0;	// ROM drives the upper byte
				end
				L0RD:
					pbusUpperOe <= 1'b0;	// Word held, ROM still driving
				SP:
					pbusOut <= {sprReq.pal, sprReq.xpos, 8'h00};
				default:
					pbusOut <= '0;
			endcase
		end
	end

	// ROM byte sampled while the L0 address is still on the bus
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
			l0Data <= '0;
		else if (slotCount == `PBUS_L0_READ)
			l0Data <= pbusUpperIn;
	end

endmodule

// ==== logic/pbusTop.sv ====
module pbusTop (
	input  logic        CLK_24M,
	input  logic        nCLK_24M,
	input  logic        HSYNC,
	input  logic        wbCyc,
	input  logic        wbStb,
	input  logic        wbWe,
	input  logic [2:0]  wbAdr,
	input  logic [31:0] wbDatW,
	output logic [31:0] wbDatR,
	output logic        wbAck,
	output logic [23:0] pbusOut,
	output logic        pbusUpperOe,
	input  logic [7:0]  pbusUpperIn,
	output logic        PCK1,
	output logic        PCK2,
	output logic        LOAD,
	output logic        nVCS
);

	import pbus_pkg::*;

	fixReq_t    fixHost;
	fixReq_t    fixLine;
	sprReq_t    sprHost;
	sprReq_t    sprLine;
	l0Addr_t    l0AddrHost;
	logic [7:0] l0Data;
	logic [4:0] slotCount;
	slotKind_t  slotKind;

	wbRegs regs (
		.CLK_24M(CLK_24M), .nCLK_24M(nCLK_24M),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.fixHost(fixHost), .sprHost(sprHost), .l0AddrHost(l0AddrHost),
		.l0Data(l0Data)
	);

	reqLatch #(.payload_t(fixReq_t)) fixLatch (
		.CLK_24M(CLK_24M), .nCLK_24M(nCLK_24M), .HSYNC(HSYNC),
		.hostVal(fixHost), .lineVal(fixLine)
	);

	reqLatch #(.payload_t(sprReq_t)) sprLatch (
		.CLK_24M(CLK_24M), .nCLK_24M(nCLK_24M), .HSYNC(HSYNC),
		.hostVal(sprHost), .lineVal(sprLine)
	);

	pbusSequencer seq (
		.CLK_24M(CLK_24M), .nCLK_24M(nCLK_24M), .HSYNC(HSYNC),
		.slotCount(slotCount), .slotKind(slotKind),
		.PCK1(PCK1), .PCK2(PCK2), .LOAD(LOAD), .nVCS(nVCS)
	);

	pbusDriver drv (
		.CLK_24M(CLK_24M), .nCLK_24M(nCLK_24M), .HSYNC(HSYNC),
		.slotCount(slotCount), .slotKind(slotKind),
		.fixReq(fixLine), .sprReq(sprLine), .l0AddrHost(l0AddrHost),
		.pbusUpperIn(pbusUpperIn), .pbusOut(pbusOut),
		.pbusUpperOe(pbusUpperOe), .l0Data(l0Data)
	);

endmodule

// ==== tests/pbus_assertions.sv ====
module pbusAssertions (
	input logic       CLK_24M,
	input logic       nCLK_24M,
	input logic       HSYNC,
	input logic [4:0] slotCount,
	input logic       PCK1,
	input logic       PCK2
);

	// Counter restarts and holds at zero through HSYNC
	countHeld: assert property (@(posedge CLK_24M) disable iff (nCLK_24M)
		HSYNC && !nCLK_24M |=> slotCount == 5'd0)
		else $error("slotCount not zero after HSYNC high");

	countStep: assert property (@(posedge CLK_24M) disable iff (nCLK_24M)
		!HSYNC && !nCLK_24M |=> slotCount == $past(slotCount) + 5'd1)	// 31 wraps to 0
		else $error("slotCount did not advance by one");

	// PCK1 trails PCK2 by eight clocks
	pckSpacing: assert property (@(posedge CLK_24M) disable iff (nCLK_24M)
		PCK1 |-> $past(PCK2, 8))
		else $error("PCK1 high without PCK2 eight clocks before");

endmodule

bind pbusSequencer pbusAssertions seqChecks (
	.CLK_24M(CLK_24M),
	.nCLK_24M(nCLK_24M),
	.HSYNC(HSYNC),
	.slotCount(slotCount),
	.PCK1(PCK1),
	.PCK2(PCK2)
);

// ==== tests/pbusTb.sv ====
`include "pbus_params.svh"

module pbusTb;

	import pbus_pkg::*;

	localparam int ENTRIES = 6;
	// Roughly 60 clocks per entry, rounded up, plus reset and spare
	localparam int CYCLE_LIMIT = ENTRIES * 80 + 100;

	logic        CLK_24M = 1'b0;
	logic        nCLK_24M;
	logic        HSYNC;
	logic        wbCyc;
	logic        wbStb;
	logic        wbWe;
	logic [2:0]  wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic        wbAck;
	logic [23:0] pbusOut;
	logic        pbusUpperOe;
	logic [7:0]  pbusUpperIn;
	logic        PCK1;
	logic        PCK2;
	logic        LOAD;
	logic        nVCS;

	fixReq_t    fixTab [ENTRIES];
	sprReq_t    sprTab [ENTRIES];
	l0Addr_t    l0Tab [ENTRIES];
	logic [7:0] romTab [ENTRIES];	// Expected L0 capture per entry
	int         cycles = 0;

	pbusTop UUT (.*);

	always #10 CLK_24M = ~CLK_24M;

	always @(posedge CLK_24M)
	begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout, run still busy after %0d cycles", cycles);
			stopRun();
		end
	end

	// ROM model answers whenever the upper byte is released
	initial
	begin
		pbusUpperIn = 8'h00;
		forever
		begin
			@(posedge CLK_24M);
			#2;
			pbusUpperIn = pbusUpperOe ? 8'h00 : (pbusOut[7:0] ^ 8'hA5);
		end
	end

	task automatic stopRun();
		$display("Test failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkWord(input string name, input logic [23:0] exp,
		input logic [23:0] act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
			stopRun();
		end
	endtask

	task automatic checkData(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
			stopRun();
		end
	endtask

	task automatic checkStrobes(input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: PCK1/PCK2/LOAD expected %b, got %b", $time, exp, act);
			stopRun();
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
			stopRun();
		end
	endtask

	task automatic nextCycle();
		@(posedge CLK_24M);
		#2;
	endtask

	// One classic cycle, ack due in the very next clock
	task automatic wbAccess(input logic we, input logic [2:0] adr, input logic [31:0] dat,
		output logic [31:0] rd);
		nextCycle();
		checkBit("wbAck", 1'b0, wbAck);	// Previous ack lasted one clock
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = dat;
		nextCycle();
		checkBit("wbAck", 1'b1, wbAck);
		rd = wbDatR;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input logic [2:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		wbAccess(1'b1, adr, dat, unused);
	endtask

	task automatic readCheck(input logic [2:0] adr, input logic [31:0] exp);
		logic [31:0] rd;
		wbAccess(1'b0, adr, 32'h0, rd);
		checkData("wbDatR", exp, rd);
	endtask

	// Expected bus word for slot c, per the window layout
	function automatic logic [23:0] slotWord(input logic [4:0] c, input fixReq_t fix,
		input sprReq_t spr, input l0Addr_t l0);
		if (c <= `PBUS_FIXT_END)
			return {8'h00, fix.addr[4], fix.addr[2:0], fix.addr[16:5]};
		else if (c <= `PBUS_FF_END)
			return 24'hFF0000;
		else if (c <= `PBUS_FP_END)
			return {4'h0, fix.pal, 16'h0000};
		else if (c <= `PBUS_SPRT_END)
			return {spr.addr[24:21], spr.addr[3:0], spr.addr[20:5]};
		else if (c <= `PBUS_L0_READ)
			return {8'h00, l0};	// Capture slot keeps the L0 word
		else
			return {spr.pal, spr.xpos, 8'h00};
	endfunction

	// HSYNC pulse, then one full line checked slot by slot
	task automatic runLine(input fixReq_t fix, input sprReq_t spr, input l0Addr_t l0);
		int k;
		logic [4:0] cnt;
		logic [4:0] prev;
		nextCycle();
		HSYNC = 1'b1;
		repeat (2) nextCycle();
		HSYNC = 1'b0;
		cnt = 5'd0;
		for (k = 1; k <= `PBUS_SLOTS; k++)
		begin
			nextCycle();
			prev = cnt;
			cnt = cnt + 5'd1;
			checkStrobes({cnt[3:0] == 4'd8, cnt[3:0] == 4'd0, cnt[2:0] >= 3'd6},
				{PCK1, PCK2, LOAD});
			checkWord("pbusOut", slotWord(prev, fix, spr, l0), pbusOut);
			checkBit("pbusUpperOe", !(prev > `PBUS_SPRT_END && prev <= `PBUS_L0_READ),
				pbusUpperOe);
			if (prev >= 5'd9)	// From the first fall on, nVCS is set by this line
				checkBit("nVCS", !(prev[3:0] >= `PBUS_VCS_FALL && prev[3:0] < `PBUS_VCS_RISE),
					nVCS);
			if (k == 3)
			begin
				// Mid-line palette change, must stay invisible until next HSYNC
				wbCyc = 1'b1;
				wbStb = 1'b1;
				wbWe = 1'b1;
				wbAdr = `REG_FIXPAL;
				wbDatW = {28'h0, ~fix.pal};
			end
			else if (k == 4)
			begin
				checkBit("wbAck", 1'b1, wbAck);
				wbCyc = 1'b0;
				wbStb = 1'b0;
				wbWe = 1'b0;
			end
		end
	endtask

	initial
	begin
		logic [31:0] r;
		logic [7:0] lastL0;
		int i;
		int e;
		void'($urandom(32'hcf03_854e));
		nCLK_24M = 1'b1;
		HSYNC = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = 3'd0;
		wbDatW = 32'h0;

		// Corner entries first, the rest random
		fixTab[0] = '0;
		sprTab[0] = '0;
		l0Tab[0] = '0;
		fixTab[1] = '1;
		sprTab[1] = '1;
		l0Tab[1] = '1;
		for (i = 2; i < ENTRIES; i++)
		begin
			r = $urandom;
			fixTab[i] = r[20:0];
			r = $urandom;
			l0Tab[i] = r[15:0];
			sprTab[i] = {r[24:16], $urandom()};
		end
		for (i = 0; i < ENTRIES; i++)
			romTab[i] = l0Tab[i][7:0] ^ 8'hA5;

		repeat (3) nextCycle();
		checkWord("pbusOut", 24'h0, pbusOut);	// Still in reset here
		checkBit("pbusUpperOe", 1'b0, pbusUpperOe);
		checkBit("nVCS", 1'b1, nVCS);
		checkBit("wbAck", 1'b0, wbAck);
		checkStrobes(3'b010, {PCK1, PCK2, LOAD});
		nCLK_24M = 1'b0;
		readCheck(`REG_FIXADDR, 32'h0);
		readCheck(`REG_L0DATA, 32'h0);
		lastL0 = 8'h00;

		for (e = 0; e < ENTRIES; e++)
		begin
			// Junk above each field must be masked off
			wbWrite(`REG_FIXADDR, {15'h7FFF, fixTab[e].addr});
			wbWrite(`REG_FIXPAL, {28'hFFF_FFFF, fixTab[e].pal});
			wbWrite(`REG_SPRADDR, {7'h7F, sprTab[e].addr});
			wbWrite(`REG_SPRATTR, {16'hFFFF, sprTab[e].pal, sprTab[e].xpos});
			wbWrite(`REG_L0ADDR, {16'hFFFF, l0Tab[e]});
			wbWrite(`REG_L0DATA, 32'hFFFF_FFFF);
			readCheck(`REG_L0DATA, {24'h0, lastL0});	// Read only register
			readCheck(`REG_FIXADDR, {15'h0, fixTab[e].addr});
			readCheck(`REG_FIXPAL, {28'h0, fixTab[e].pal});
			readCheck(`REG_SPRADDR, {7'h0, sprTab[e].addr});
			readCheck(`REG_SPRATTR, {16'h0, sprTab[e].pal, sprTab[e].xpos});
			readCheck(`REG_L0ADDR, {16'h0, l0Tab[e]});
			runLine(fixTab[e], sprTab[e], l0Tab[e]);
			readCheck(`REG_L0DATA, {24'h0, romTab[e]});
			lastL0 = romTab[e];
		end

		$display("Test passed");
		$finish;
	end

endmodule

// ==== pbusCycle.f ====
+incdir+common
common/pbus_pkg.sv
logic/reqLatch.sv
logic/wbRegs.sv
pbus/pbusSequencer.sv
pbus/pbusDriver.sv
logic/pbusTop.sv
tests/pbus_assertions.sv
tests/pbusTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= pbusTb
FILELIST  ?= pbusCycle.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
